// ==== hdl/pool_pkg.sv ====
`default_nettype none

package pool_pkg;

    // one pixel word, unsigned
    typedef logic [15:0] pixel_t;

    // row parity of the 2x2 window
    typedef enum logic {
        ROW_EVEN = 1'b0,  // pair maxima go into the line buffer
        ROW_ODD  = 1'b1   // line buffer is read, block maxima come out
    } row_phase_e;

    // image is IMG_W x IMG_W, must be even and >= 4
    parameter int IMG_W_DEFAULT = 8;

endpackage

`default_nettype wire

// ==== hdl/pool_ctrl.sv ====
`timescale 1ns/1ns
`default_nettype none

module pool_ctrl #(
    parameter int IMG_W = 8
) (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                pix_valid,
    output logic                                     hold_en,
    output logic                                     buf_wr,
    output logic                                     blk_en,
    output logic [$clog2(IMG_W/2)-1:0]               buf_addr,
    output logic                                     pool_valid,
    output logic                                     frame_done
);

    localparam int ADDR_W = $clog2(IMG_W/2);
    localparam int COL_W  = ADDR_W + 1;       // column = {pair index, lsb}
    localparam logic [COL_W-1:0]  COL_LAST  = COL_W'(IMG_W - 1);
    localparam logic [ADDR_W-1:0] PAIR_LAST = ADDR_W'(IMG_W/2 - 1);

    logic [COL_W-1:0]     col;                // current column
    logic [ADDR_W-1:0]    row_pair;           // which pair of rows we are in
    pool_pkg::row_phase_e phase;
    pool_pkg::row_phase_e phase_nxt;
    logic                 row_end;            // valid pixel in the last column
    logic                 odd_col;
    logic                 last_blk;           // bottom-right block of the frame

    assign odd_col  = col[0];
    assign row_end  = pix_valid && (col == COL_LAST);
    assign last_blk = row_end && (phase == pool_pkg::ROW_ODD) && (row_pair == PAIR_LAST);

    // strobes decoded straight from the counters, qualified by the input strobe
    assign hold_en  = pix_valid && !odd_col;
    assign buf_wr   = pix_valid && odd_col && (phase == pool_pkg::ROW_EVEN);
    assign blk_en   = pix_valid && odd_col && (phase == pool_pkg::ROW_ODD);
    assign buf_addr = col[COL_W-1:1];         // same slot for write and read

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= '0;
        end else if (row_end) begin
            col <= '0;                        // wrap at end of row
        end else if (pix_valid) begin
            col <= col + 1'b1;
        end
    end

    // row phase flips at every row end
    always_comb begin
        phase_nxt = phase;
        if (row_end) begin
            case (phase)
                pool_pkg::ROW_EVEN: phase_nxt = pool_pkg::ROW_ODD;
                default:            phase_nxt = pool_pkg::ROW_EVEN;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            phase <= pool_pkg::ROW_EVEN;
        end else begin
            phase <= phase_nxt;
        end
    end

    // counts completed row pairs; only used to find the end of frame
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_pair <= '0;
        end else if (row_end && phase == pool_pkg::ROW_ODD) begin
            if (row_pair == PAIR_LAST) begin
                row_pair <= '0;
            end else begin
                row_pair <= row_pair + 1'b1;
            end
        end
    end

    // output pulses, one clock after the bottom-right pixel of a block
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pool_valid <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            pool_valid <= blk_en;
            frame_done <= last_blk;           // lines up with the last pool_valid
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pool_line_buffer.sv ====
`timescale 1ns/1ns
`default_nettype none

module pool_line_buffer #(
    parameter int IMG_W = 8
) (
    input  wire logic                         clk,
    input  wire logic                         wr,
    input  wire logic [$clog2(IMG_W/2)-1:0]   addr,
    input  wire pool_pkg::pixel_t             din,
    output pool_pkg::pixel_t                  dout
);

    localparam int DEPTH = IMG_W / 2;         // one entry per column pair

    pool_pkg::pixel_t mem [DEPTH];

    // even row writes pair maxima
    always_ff @(posedge clk) begin
        if (wr) begin
            mem[addr] <= din;
        end
    end

    // odd row reads the same slot back in the same cycle as the pixel
    assign dout = mem[addr];

endmodule

`default_nettype wire

// ==== hdl/pool_max_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module pool_max_unit (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire pool_pkg::pixel_t pix,
    input  wire logic             hold_en,
    input  wire logic             blk_en,
    input  wire pool_pkg::pixel_t buf_rd,
    output pool_pkg::pixel_t      pair_max,
    output pool_pkg::pixel_t      pool_out
);

    pool_pkg::pixel_t left_pix;               // even-column pixel of the pair
    pool_pkg::pixel_t blk_max;

    // left pixel of the current pair
    always_ff @(posedge clk) begin
        if (hold_en) begin
            left_pix <= pix;
        end
    end

    // horizontal max, valid while the odd-column pixel is on pix
    always_comb begin
        if (pix > left_pix) begin
            pair_max = pix;
        end else begin
            pair_max = left_pix;
        end
    end

    // vertical max against the pair parked from the row above
    always_comb begin
        if (pair_max > buf_rd) begin
            blk_max = pair_max;
        end else begin
            blk_max = buf_rd;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pool_out <= '0;
        end else if (blk_en) begin
            pool_out <= blk_max;              // held until the next block
        end
    end

endmodule

`default_nettype wire

// ==== hdl/pool_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module pool_top #(
    parameter int IMG_W = pool_pkg::IMG_W_DEFAULT
) (
    input  wire logic             clk,
    input  wire logic             rst_n,
    input  wire pool_pkg::pixel_t pix,
    input  wire logic             pix_valid,
    output pool_pkg::pixel_t      pool_out,
    output logic                  pool_valid,
    output logic                  frame_done
);

    localparam int ADDR_W = $clog2(IMG_W/2);

    logic              hold_en;               // capture left pixel of a pair
    logic              buf_wr;                // park pair max, even rows
    logic              blk_en;                // finish a block, odd rows
    logic [ADDR_W-1:0] buf_addr;
    pool_pkg::pixel_t  pair_max;
    pool_pkg::pixel_t  buf_rd;

    pool_ctrl #(
        .IMG_W      (IMG_W)
    ) i_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .pix_valid  (pix_valid),
        .hold_en    (hold_en),
        .buf_wr     (buf_wr),
        .blk_en     (blk_en),
        .buf_addr   (buf_addr),
        .pool_valid (pool_valid),
        .frame_done (frame_done)
    );

    pool_line_buffer #(
        .IMG_W (IMG_W)
    ) i_line_buffer (
        .clk   (clk),
        .wr    (buf_wr),
        .addr  (buf_addr),
        .din   (pair_max),
        .dout  (buf_rd)
    );

    pool_max_unit i_max_unit (
        .clk      (clk),
        .rst_n    (rst_n),
        .pix      (pix),
        .hold_en  (hold_en),
        .blk_en   (blk_en),
        .buf_rd   (buf_rd),
        .pair_max (pair_max),
        .pool_out (pool_out)
    );

endmodule

`default_nettype wire

// ==== tests/clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module clk_gen #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;      // 50/50 duty cycle
        end
    end

endmodule

`default_nettype wire

// ==== tests/pool_props.sv ====
`timescale 1ns/1ns
`default_nettype none

module pool_props (
    input wire logic clk,
    input wire logic rst_n,
    input wire logic blk_en,
    input wire logic pool_valid,
    input wire logic frame_done
);

    int n_fail = 0;                           // read by the testbench at the end

    a_single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        pool_valid |=> !pool_valid)
        else begin
            n_fail++;
            $error("pool_valid high on two cycles in a row");
        end

    a_quiet_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !pool_valid)
        else begin
            n_fail++;
            $error("pool_valid high right after reset release");
        end

    a_done_with_valid: assert property (@(posedge clk) disable iff (!rst_n)
        frame_done |-> pool_valid)
        else begin
            n_fail++;
            $error("frame_done without pool_valid");
        end

    a_blk_then_valid: assert property (@(posedge clk) disable iff (!rst_n)
        blk_en |=> pool_valid)
        else begin
            n_fail++;
            $error("blk_en not followed by pool_valid");
        end

endmodule

bind pool_top pool_props i_props (
    .clk        (clk),
    .rst_n      (rst_n),
    .blk_en     (blk_en),
    .pool_valid (pool_valid),
    .frame_done (frame_done)
);

`default_nettype wire

// ==== tests/tb_pool.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_pool;

    localparam int IMG_W       = pool_pkg::IMG_W_DEFAULT;
    localparam int HALF        = IMG_W / 2;
    localparam int N_PIX       = IMG_W * IMG_W;
    localparam int N_BLK       = HALF * HALF;
    localparam int TIMEOUT_CYC = 4000;

    logic             clk;
    logic             rst_n;
    pool_pkg::pixel_t pix;
    logic             pix_valid;
    pool_pkg::pixel_t pool_out;
    logic             pool_valid;
    logic             frame_done;

    pool_pkg::pixel_t frame [N_PIX];          // current frame, raster order
    pool_pkg::pixel_t exp_val[$];             // expected block maxima
    int               exp_cyc[$];             // cycle where pool_valid must be seen
    bit               exp_last[$];            // last block of a frame
    int               rd_idx    = 0;          // next entry the compare process takes
    int               cyc       = 0;
    int               chk_err   = 0;
    int               main_err  = 0;
    int               done_cnt  = 0;
    int               err_start = 0;
    int               done_start = 0;
    int               n_ok      = 0;
    int               n_bad     = 0;

    clk_gen #(.PERIOD_NS(100)) i_clk_gen (.clk(clk));

    pool_top #(
        .IMG_W      (IMG_W)
    ) i_dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .pix        (pix),
        .pix_valid  (pix_valid),
        .pool_out   (pool_out),
        .pool_valid (pool_valid),
        .frame_done (frame_done)
    );

    // max of the four pixels of one 2x2 block
    function automatic pool_pkg::pixel_t block_max(input pool_pkg::pixel_t f [N_PIX],
                                                   input int blk);
        int               base;
        pool_pkg::pixel_t m;
        base = 2 * (blk / HALF) * IMG_W + 2 * (blk % HALF);
        m = f[base];
        if (f[base + 1] > m) m = f[base + 1];
        if (f[base + IMG_W] > m) m = f[base + IMG_W];
        if (f[base + IMG_W + 1] > m) m = f[base + IMG_W + 1];
        return m;
    endfunction

    function automatic int err_total();
        return chk_err + main_err + i_dut.i_props.n_fail;
    endfunction

    task automatic fill_random_frame();
        for (int i = 0; i < N_PIX; i++) begin
            frame[i] = pool_pkg::pixel_t'($urandom);
        end
    endtask

    // block maximum rotates through the four corners, with 16'hFFFF and ties mixed in
    task automatic build_corner_frame(input int rot);
        int               offs [4] = '{0, 1, IMG_W, IMG_W + 1};
        int               base;
        int               corner;
        pool_pkg::pixel_t top;
        for (int blk = 0; blk < N_BLK; blk++) begin
            base = 2 * (blk / HALF) * IMG_W + 2 * (blk % HALF);
            for (int k = 0; k < 4; k++) begin
                frame[base + offs[k]] = pool_pkg::pixel_t'($urandom_range(16'h7fff, 0));
            end
            corner = (blk + rot) % 4;
            top = (blk % 3 == 0) ? 16'hffff
                                 : pool_pkg::pixel_t'(16'h8000 | $urandom_range(16'h7fff, 0));
            frame[base + offs[corner]] = top;
            if (blk % 5 == 0) begin
                frame[base + offs[(corner + 2) % 4]] = top;  // tie in the other row, same column
            end
        end
    endtask

    task automatic go_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            pix_valid <= 1'b0;
        end
    endtask

    // sends the first n_pix pixels of frame with 0..max_gap idle cycles before each
    task automatic send_frame(input int max_gap, input int n_pix);
        int gap;
        int row;
        int col;
        int blk;
        for (int i = 0; i < n_pix; i++) begin
            gap = (max_gap > 0) ? $urandom_range(max_gap, 0) : 0;
            repeat (gap) begin
                @(posedge clk);
                pix       <= pool_pkg::pixel_t'($urandom);  // junk while idle
                pix_valid <= 1'b0;
            end
            @(posedge clk);
            pix       <= frame[i];
            pix_valid <= 1'b1;
            row = i / IMG_W;
            col = i % IMG_W;
            if (row % 2 == 1 && col % 2 == 1) begin
                blk = (row / 2) * HALF + col / 2;
                exp_val.push_back(block_max(frame, blk));
                exp_cyc.push_back(cyc + 2);   // sampled next edge, seen one edge later
                exp_last.push_back(blk == N_BLK - 1);
            end
        end
    endtask

    task automatic start_test();
        err_start  = err_total();
        done_start = done_cnt;
    endtask

    task automatic finish_test(input int num, input string name, input int exp_frames);
        int k;
        k = 0;
        while (exp_val.size() - rd_idx > 0 && k < 8) begin
            @(posedge clk);
            pix_valid <= 1'b0;
            k++;
        end
        go_idle(2);
        if (exp_val.size() - rd_idx > 0) begin
            main_err++;
            $display("%0d expected blocks never came out of the DUT", exp_val.size() - rd_idx);
        end
        if (done_cnt - done_start != exp_frames) begin
            main_err++;
            $display("ERR t=%0t frame_done count: expected %0d got %0d",
                     $time, exp_frames, done_cnt - done_start);
        end
        if (err_total() == err_start) begin
            n_ok++;
            $display("test %0d %s: ok", num, name);
        end else begin
            n_bad++;
            $display("test %0d %s: failed with %0d errors", num, name, err_total() - err_start);
        end
    endtask

    // compare process
    always @(posedge clk) begin
        if (!rst_n) begin
            rd_idx = exp_val.size();          // blocks in flight are lost on reset
            if (pool_valid) begin
                chk_err++;
                $display("pool_valid high at t=%0t while reset is held", $time);
            end
        end else if (pool_valid) begin
            if (rd_idx >= exp_val.size()) begin
                chk_err++;
                $display("pool_valid at t=%0t with no block expected", $time);
            end else begin
                if (pool_out !== exp_val[rd_idx]) begin
                    chk_err++;
                    $display("ERR t=%0t pool_out: expected %h got %h",
                             $time, exp_val[rd_idx], pool_out);
                end
                if (cyc != exp_cyc[rd_idx]) begin
                    chk_err++;
                    $display("ERR t=%0t pool_valid cycle: expected %0d got %0d",
                             $time, exp_cyc[rd_idx], cyc);
                end
                if (frame_done !== exp_last[rd_idx]) begin
                    chk_err++;
                    $display("frame_done at t=%0t does not match the last block of the frame",
                             $time);
                end
                rd_idx++;
            end
            if (frame_done) done_cnt++;
        end else if (frame_done) begin
            chk_err++;
            $display("frame_done at t=%0t came without pool_valid", $time);
        end
    end

    // run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= TIMEOUT_CYC) begin
            $display("run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial begin
        void'($urandom(54));
        rst_n     = 1'b0;
        pix       = '0;
        pix_valid = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        go_idle(2);

        start_test();
        fill_random_frame();
        send_frame(0, N_PIX);
        finish_test(1, "continuous frame", 1);

        start_test();
        fill_random_frame();
        send_frame(3, N_PIX);
        finish_test(2, "gapped strobes", 1);

        start_test();
        build_corner_frame(0);
        send_frame(0, N_PIX);
        go_idle(1);
        build_corner_frame(1);
        send_frame(1, N_PIX);
        finish_test(3, "max in each corner", 2);

        start_test();
        fill_random_frame();
        send_frame(0, N_PIX);
        fill_random_frame();
        send_frame(0, N_PIX);                 // no idle cycle between frames
        finish_test(4, "back-to-back frames", 2);

        start_test();
        fill_random_frame();
        send_frame(1, ((IMG_W / 2) | 1) * IMG_W + IMG_W / 2);  // stop part-way through an odd row
        go_idle(1);
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        go_idle(1);
        fill_random_frame();
        send_frame(0, N_PIX);
        finish_test(5, "reset mid-frame", 1);

        $display("summary: %0d tests ok, %0d tests with errors, %0d errors in total",
                 n_ok, n_bad, err_total());
        if (n_bad == 0 && err_total() == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb.f ====
hdl/pool_pkg.sv
hdl/pool_ctrl.sv
hdl/pool_line_buffer.sv
hdl/pool_max_unit.sv
hdl/pool_top.sv
tests/clk_gen.sv
tests/pool_props.sv
tests/tb_pool.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the pooling testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module tb_pool -f tb.f -o tb_pool_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_pool_sim +verilator+error+limit+1000 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^TESTS PASSED$" "$LOG"; then
    echo "result: pass"
    exit 0
else
    echo "result: fail"
    exit 1
fi
